//--- src.f
+incdir+hw
hw/desc_format_pkg.sv
hw/prefetch_ctrl_pkg.sv
hw/desc_fetch_master.sv
hw/prefetch_ctrl.sv
hw/desc_prefetcher.sv
bench/desc_mem_model.sv
bench/desc_prefetcher_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the descriptor prefetcher testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module desc_prefetcher_tb -o desc_prefetcher_sim

out=$(./obj_dir/desc_prefetcher_sim)
echo "$out"

# Exit status follows the search for the pass message
echo "$out" | grep -q "ALL TESTS PASSED"

//--- bench/desc_prefetcher_tb.sv
`timescale 1ns/1ps
`include "prefetch_defs.svh"

module desc_prefetcher_tb
    import desc_format_pkg::*;
();

    localparam int TIMEOUT = 2000;
    localparam int SEED    = 13639;

    localparam logic [31:0] ADDR_A = 32'h0000_0100;
    localparam logic [31:0] ADDR_B = 32'h0000_0840;
    localparam logic [31:0] ADDR_C = 32'h0000_03c0;
    localparam logic [31:0] ADDR_D = 32'h0000_0600;
    localparam logic [31:0] ADDR_P = 32'h0000_0900;
    localparam logic [31:0] ADDR_Q = 32'h0000_0a00;

    typedef enum int {W_CLEAR_RUN, W_DRAINED, W_FETCHES, W_RESET_DONE, W_RESET_LOW} wait_kind_t;

    logic                       clk;
    logic                       reset;
    logic [31:0]                mem_address;
    logic                       mem_read;
    logic [31:0]                mem_readdata;
    logic                       mem_waitrequest;
    logic                       mem_readdatavalid;
    logic                       descr_valid;
    logic                       descr_ready;
    dispatch_desc_t             descr_data;
    logic                       resp_fifo_full;
    logic                       put_resp_fifo;
    resp_word_t                 resp_fifo_wdata;
    logic                       run;
    logic                       reset_prefetcher;
    logic [31:0]                nxt_desc_ptr;
    logic                       desc_poll_en;
    logic [15:0]                desc_poll_freq;
    logic                       clear_run;
    logic                       update_nxt_desc_ptr;
    logic [31:0]                updated_ptr_desc;
    logic                       reset_complete;
    logic                       wr_en;
    logic [31:0]                wr_addr;
    logic [31:0]                wr_data;

    integer                     seed;
    bit                         random_bp;
    dispatch_desc_t             exp_desc_q [$];
    resp_word_t                 exp_resp_q [$];
    logic [31:0]                exp_ptr_q [$];
    string                      test_name;
    int                         errors;
    int                         test_err0;
    int                         tests_run;
    int                         tests_failed;
    int                         clear_runs;
    int                         read_cycles;
    int                         watch_fetches;
    logic [31:0]                watch_addr;
    bit                         hold_pending;
    dispatch_desc_t             hold_data;

    desc_prefetcher desc_prefetcher_i (
        .clk                 (clk),
        .reset               (reset),
        .mem_address         (mem_address),
        .mem_read            (mem_read),
        .mem_readdata        (mem_readdata),
        .mem_waitrequest     (mem_waitrequest),
        .mem_readdatavalid   (mem_readdatavalid),
        .descr_valid         (descr_valid),
        .descr_ready         (descr_ready),
        .descr_data          (descr_data),
        .resp_fifo_full      (resp_fifo_full),
        .put_resp_fifo       (put_resp_fifo),
        .resp_fifo_wdata     (resp_fifo_wdata),
        .run                 (run),
        .reset_prefetcher    (reset_prefetcher),
        .nxt_desc_ptr        (nxt_desc_ptr),
        .desc_poll_en        (desc_poll_en),
        .desc_poll_freq      (desc_poll_freq),
        .clear_run           (clear_run),
        .update_nxt_desc_ptr (update_nxt_desc_ptr),
        .updated_ptr_desc    (updated_ptr_desc),
        .reset_complete      (reset_complete)
    );

    desc_mem_model #(.SEED(SEED)) mem_i (
        .clk           (clk),
        .reset         (reset),
        .address       (mem_address),
        .read          (mem_read),
        .waitrequest   (mem_waitrequest),
        .readdata      (mem_readdata),
        .readdatavalid (mem_readdatavalid),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Expected stream word and response word for one fetched descriptor
    function automatic void expect_desc(input mem_desc_t d, input logic [31:0] addr,
                                        output dispatch_desc_t dd, output resp_word_t rw);
        dd.tag        = 2'b10;
        dd.flags      = d.control.flags;
        dd.length     = d.length;
        dd.write_addr = d.write_addr;
        dd.read_addr  = d.read_addr;
        rw.control    = d.control;
        rw.fetch_addr = addr;
    endfunction

    function automatic mem_desc_t make_desc(input logic [31:0] src, input logic [31:0] dst,
                                            input logic [31:0] len, input logic [31:0] nxt,
                                            input logic owned, input logic [29:0] flags);
        mem_desc_t d;
        d.read_addr           = src;
        d.write_addr          = dst;
        d.length              = len;
        d.next_ptr            = nxt;
        d.reserved            = {32'h5eed_0006, 32'h5eed_0005, 32'h5eed_0004};
        d.control.go          = 1'b1;
        d.control.owned_by_hw = owned;
        d.control.flags       = flags;
        return d;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic push_expected(input mem_desc_t d, input logic [31:0] addr);
        dispatch_desc_t dd;
        resp_word_t     rw;
        expect_desc(d, addr, dd, rw);
        exp_desc_q.push_back(dd);
        exp_resp_q.push_back(rw);
    endtask

    task automatic write_desc(input logic [31:0] addr, input mem_desc_t d);
        for (int k = 0; k < `PF_DESC_WORDS; k++) begin
            wr_en   = 1'b1;
            wr_addr = addr + 32'(`PF_ADDR_STEP * k);
            wr_data = d[k*32 +: 32];
            step();
        end
        wr_en = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_err0) begin
            tests_failed++;
            $display("Test %s failed with %0d errors", test_name, errors - test_err0);
        end else begin
            $display("Test %s passed", test_name);
        end
    endtask

    task automatic timed_out(input string what);
        $display("Timeout in test %s while waiting for %s", test_name, what);
        errors++;
    endtask

    // Polls at the falling edge so that counters and outputs have settled
    task automatic wait_until(input wait_kind_t kind, input int target, input string what);
        int  n;
        bit  hit;
        n   = 0;
        hit = 1'b0;
        while (!hit && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            case (kind)
                W_CLEAR_RUN:  hit = clear_run;
                W_DRAINED:    hit = (exp_desc_q.size() == 0) && (exp_resp_q.size() == 0) &&
                                    (exp_ptr_q.size() == 0);
                W_FETCHES:    hit = (watch_fetches >= target);
                W_RESET_DONE: hit = reset_complete;
                W_RESET_LOW:  hit = !reset_complete;
                default:      hit = 1'b0;
            endcase
        end
        if (!hit) begin
            timed_out(what);
        end
    endtask

    // Random stretches of stream and response back-pressure
    initial begin : backpressure
        int          ready_left;
        int          full_left;
        logic [31:0] rnd;
        descr_ready    = 1'b1;
        resp_fifo_full = 1'b0;
        ready_left     = 0;
        full_left      = 0;
        forever begin
            @(posedge clk);
            #1;
            if (!random_bp) begin
                descr_ready    = 1'b1;
                resp_fifo_full = 1'b0;
            end else begin
                if (ready_left == 0) begin
                    rnd         = $random(seed);
                    descr_ready = rnd[0];
                    ready_left  = 1 + int'(rnd[3:1]);
                end
                if (full_left == 0) begin
                    rnd            = $random(seed);
                    resp_fifo_full = rnd[0] & rnd[1];
                    full_left      = 1 + int'(rnd[4:2]);
                end
                ready_left--;
                full_left--;
            end
        end
    end

    // Comparing process sampling DUT outputs at each rising edge
    always @(posedge clk) begin : compare
        dispatch_desc_t exp_d;
        resp_word_t     exp_r;
        logic [31:0]    exp_p;
        if (!reset) begin
            if (hold_pending) begin
                if (!descr_valid) begin
                    $display("In test %s descr_valid dropped before the handshake", test_name);
                    errors++;
                end else if (descr_data !== hold_data) begin
                    $display("Fail %s expected %h actual %h", test_name, hold_data, descr_data);
                    errors++;
                end
            end
            hold_pending = descr_valid && !descr_ready;
            hold_data    = descr_data;
            if (descr_valid && descr_ready) begin
                if (exp_desc_q.size() == 0) begin
                    $display("In test %s an unexpected stream word %h appeared", test_name,
                             descr_data);
                    errors++;
                end else begin
                    exp_d = exp_desc_q.pop_front();
                    if (descr_data !== exp_d) begin
                        $display("Fail %s expected %h actual %h", test_name, exp_d, descr_data);
                        errors++;
                    end
                end
            end
            if (put_resp_fifo) begin
                if (exp_resp_q.size() == 0) begin
                    $display("In test %s an unexpected response %h was written", test_name,
                             resp_fifo_wdata);
                    errors++;
                end else begin
                    exp_r = exp_resp_q.pop_front();
                    if (resp_fifo_wdata !== exp_r) begin
                        $display("Fail %s expected %h actual %h", test_name, exp_r,
                                 resp_fifo_wdata);
                        errors++;
                    end
                end
            end
            if (update_nxt_desc_ptr) begin
                if (exp_ptr_q.size() == 0) begin
                    $display("In test %s update_nxt_desc_ptr pulsed unexpectedly", test_name);
                    errors++;
                end else begin
                    exp_p = exp_ptr_q.pop_front();
                    if (updated_ptr_desc !== exp_p) begin
                        $display("Fail %s expected %h actual %h", test_name, exp_p,
                                 updated_ptr_desc);
                        errors++;
                    end
                end
            end
            if (clear_run) begin
                clear_runs++;
            end
            if (mem_read) begin
                read_cycles++;
                if (!mem_waitrequest && mem_address == watch_addr) begin
                    watch_fetches++;
                end
            end
        end
    end

    initial begin : stimulus
        mem_desc_t da;
        mem_desc_t db;
        mem_desc_t dc;
        mem_desc_t dd;
        mem_desc_t dp;
        mem_desc_t dq;
        int        cr0;
        int        rd0;
        seed             = SEED;
        random_bp        = 1'b0;
        errors           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        clear_runs       = 0;
        read_cycles      = 0;
        watch_fetches    = 0;
        watch_addr       = 32'hffff_ffff;
        hold_pending     = 1'b0;
        hold_data        = '0;
        test_name        = "setup";
        reset            = 1'b1;
        run              = 1'b0;
        reset_prefetcher = 1'b0;
        nxt_desc_ptr     = '0;
        desc_poll_en     = 1'b0;
        desc_poll_freq   = '0;
        wr_en            = 1'b0;
        wr_addr          = '0;
        wr_data          = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        da = make_desc(32'h1000_0000, 32'h2000_0000, 32'h0000_0040, ADDR_B, 1'b1, 30'h11);
        db = make_desc(32'h1000_1000, 32'h2000_4000, 32'h0000_0800, ADDR_C, 1'b1, 30'h2a5);
        dc = make_desc(32'h1003_0000, 32'h2100_0000, 32'h0001_0000, ADDR_D, 1'b1, 30'h3c00_0001);
        dd = make_desc(32'h1004_0000, 32'h2200_0000, 32'h0000_0100, 32'h0, 1'b0, 30'h77);
        dp = make_desc(32'h1005_0000, 32'h2300_0000, 32'h0000_0200, ADDR_Q, 1'b0, 30'h1234);
        dq = make_desc(32'h1006_0000, 32'h2400_0000, 32'h0000_0300, 32'h0, 1'b0, 30'h55);
        write_desc(ADDR_A, da);
        write_desc(ADDR_B, db);
        write_desc(ADDR_C, dc);
        write_desc(ADDR_D, dd);
        write_desc(ADDR_P, dp);
        write_desc(ADDR_Q, dq);

        // Owned chain A, B, C then unowned D with polling off
        begin_test("chain_walk");
        cr0 = clear_runs;
        push_expected(da, ADDR_A);
        push_expected(db, ADDR_B);
        push_expected(dc, ADDR_C);
        nxt_desc_ptr = ADDR_A;
        run          = 1'b1;
        wait_until(W_CLEAR_RUN, 0, "clear_run at the end of the chain");
        step();
        run = 1'b0;
        wait_until(W_DRAINED, 0, "all stream words and responses");
        end_test();

        begin_test("stop_on_unowned");
        rd0 = read_cycles;
        repeat (50) step();
        if (clear_runs - cr0 != 1) begin
            $display("Fail %s expected %0d actual %0d", test_name, 1, clear_runs - cr0);
            errors++;
        end
        if (read_cycles != rd0) begin
            $display("In test %s memory reads continued after the stop", test_name);
            errors++;
        end
        end_test();

        begin_test("random_backpressure");
        random_bp = 1'b1;
        push_expected(da, ADDR_A);
        push_expected(db, ADDR_B);
        push_expected(dc, ADDR_C);
        run = 1'b1;
        wait_until(W_CLEAR_RUN, 0, "clear_run under back-pressure");
        step();
        run = 1'b0;
        wait_until(W_DRAINED, 0, "all stream words and responses");
        random_bp = 1'b0;
        repeat (20) step();
        end_test();

        begin_test("polling");
        watch_addr     = ADDR_P;
        watch_fetches  = 0;
        desc_poll_en   = 1'b1;
        desc_poll_freq = 16'd4;
        nxt_desc_ptr   = ADDR_P;
        run            = 1'b1;
        wait_until(W_FETCHES, 2, "a second fetch of the unowned descriptor");
        step();
        dp.control.owned_by_hw = 1'b1;
        push_expected(dp, ADDR_P);
        exp_ptr_q.push_back(ADDR_Q);
        write_desc(ADDR_P, dp);
        wait_until(W_DRAINED, 0, "the descriptor after its owned bit was set");
        // Descriptor Q is unowned, so stop the polling through a prefetcher reset
        step();
        reset_prefetcher = 1'b1;
        wait_until(W_CLEAR_RUN, 0, "clear_run after reset_prefetcher");
        step();
        run = 1'b0;
        wait_until(W_RESET_DONE, 0, "reset_complete to rise");
        step();
        reset_prefetcher = 1'b0;
        wait_until(W_RESET_LOW, 0, "reset_complete to fall");
        step();
        desc_poll_en = 1'b0;
        end_test();

        begin_test("prefetcher_reset");
        cr0              = clear_runs;
        rd0              = read_cycles;
        reset_prefetcher = 1'b1;
        run              = 1'b1;
        wait_until(W_RESET_DONE, 0, "reset_complete to rise");
        repeat (20) begin
            @(negedge clk);
            if (!reset_complete) begin
                $display("In test %s reset_complete fell while the request was high",
                         test_name);
                errors++;
            end
        end
        if (clear_runs == cr0) begin
            $display("In test %s clear_run never pulsed", test_name);
            errors++;
        end
        if (read_cycles != rd0) begin
            $display("Fail %s expected %0d actual %0d", test_name, rd0, read_cycles);
            errors++;
        end
        step();
        run = 1'b0;
        step();
        reset_prefetcher = 1'b0;
        wait_until(W_RESET_LOW, 0, "reset_complete to fall");
        end_test();

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
                 tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- bench/desc_mem_model.sv
`timescale 1ns/1ps
`include "prefetch_defs.svh"

module desc_mem_model #(
    parameter int SEED = 1
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`PF_ADDR_WIDTH-1:0]   address,
    input  logic                        read,
    output logic                        waitrequest,
    output logic [`PF_DATA_WIDTH-1:0]   readdata,
    output logic                        readdatavalid,
    // Test side write port
    input  logic                        wr_en,
    input  logic [`PF_ADDR_WIDTH-1:0]   wr_addr,
    input  logic [`PF_DATA_WIDTH-1:0]   wr_data
);

    localparam int DEPTH = 1024;

    logic [`PF_DATA_WIDTH-1:0] mem [DEPTH];
    logic [`PF_DATA_WIDTH-1:0] data_q [$];
    int                        due_q [$];
    int                        cycle;
    int                        last_due;
    int                        due;
    integer                    seed;
    logic [31:0]               rnd;

    initial begin
        seed          = SEED;
        cycle         = 0;
        last_due      = 0;
        waitrequest   = 1'b1;
        readdata      = '0;
        readdatavalid = 1'b0;
        // Every word gets a value tied to its full index
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'hc0de_0000 ^ (32'(i) * 32'h0001_0001);
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            data_q.delete();
            due_q.delete();
            cycle    = 0;
            last_due = 0;
        end else begin
            cycle = cycle + 1;
            if (wr_en) begin
                mem[wr_addr[11:2]] = wr_data;
            end
            if (read && !waitrequest) begin
                rnd = $random(seed);
                due = cycle + 1 + int'(rnd[1:0]);
                // Keep beats in request order, one per cycle
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                data_q.push_back(mem[address[11:2]]);
                due_q.push_back(due);
            end
        end
        #1;
        readdatavalid = 1'b0;
        if (!reset && due_q.size() > 0 && due_q[0] <= cycle) begin
            readdatavalid = 1'b1;
            readdata      = data_q.pop_front();
            void'(due_q.pop_front());
        end
        rnd         = $random(seed);
        waitrequest = (rnd[1:0] == 2'b00);
    end

endmodule

//--- hw/desc_prefetcher.sv
`timescale 1ns/1ps
`include "prefetch_defs.svh"

module desc_prefetcher
    import desc_format_pkg::*, prefetch_ctrl_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,

    // Descriptor memory read port
    output logic [`PF_ADDR_WIDTH-1:0]   mem_address,
    output logic                        mem_read,
    input  logic [`PF_DATA_WIDTH-1:0]   mem_readdata,
    input  logic                        mem_waitrequest,
    input  logic                        mem_readdatavalid,

    // Dispatcher stream
    output logic                        descr_valid,
    input  logic                        descr_ready,
    output dispatch_desc_t              descr_data,

    // Response FIFO write side
    input  logic                        resp_fifo_full,
    output logic                        put_resp_fifo,
    output resp_word_t                  resp_fifo_wdata,

    // Control and status
    input  logic                        run,
    input  logic                        reset_prefetcher,
    input  logic [`PF_ADDR_WIDTH-1:0]   nxt_desc_ptr,
    input  logic                        desc_poll_en,
    input  logic [`PF_POLL_WIDTH-1:0]   desc_poll_freq,
    output logic                        clear_run,
    output logic                        update_nxt_desc_ptr,
    output logic [`PF_ADDR_WIDTH-1:0]   updated_ptr_desc,
    output logic                        reset_complete
);

    fetch_req_t fetch_req;
    fetch_rsp_t fetch_rsp;

    desc_fetch_master desc_fetch_master_i (
        .clk               (clk),
        .reset             (reset),
        .req               (fetch_req),
        .rsp               (fetch_rsp),
        .mem_address       (mem_address),
        .mem_read          (mem_read),
        .mem_readdata      (mem_readdata),
        .mem_waitrequest   (mem_waitrequest),
        .mem_readdatavalid (mem_readdatavalid)
    );

    prefetch_ctrl prefetch_ctrl_i (
        .clk                 (clk),
        .reset               (reset),
        .run                 (run),
        .reset_prefetcher    (reset_prefetcher),
        .nxt_desc_ptr        (nxt_desc_ptr),
        .desc_poll_en        (desc_poll_en),
        .desc_poll_freq      (desc_poll_freq),
        .req                 (fetch_req),
        .rsp                 (fetch_rsp),
        .descr_valid         (descr_valid),
        .descr_ready         (descr_ready),
        .descr_data          (descr_data),
        .resp_fifo_full      (resp_fifo_full),
        .put_resp_fifo       (put_resp_fifo),
        .resp_fifo_wdata     (resp_fifo_wdata),
        .clear_run           (clear_run),
        .update_nxt_desc_ptr (update_nxt_desc_ptr),
        .updated_ptr_desc    (updated_ptr_desc),
        .reset_complete      (reset_complete)
    );

endmodule

//--- hw/prefetch_ctrl.sv
`timescale 1ns/1ps
`include "prefetch_defs.svh"

module prefetch_ctrl
    import desc_format_pkg::*, prefetch_ctrl_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        run,
    input  logic                        reset_prefetcher,
    input  logic [`PF_ADDR_WIDTH-1:0]   nxt_desc_ptr,
    input  logic                        desc_poll_en,
    input  logic [`PF_POLL_WIDTH-1:0]   desc_poll_freq,

    output fetch_req_t                  req,
    input  fetch_rsp_t                  rsp,

    output logic                        descr_valid,
    input  logic                        descr_ready,
    output dispatch_desc_t              descr_data,

    input  logic                        resp_fifo_full,
    output logic                        put_resp_fifo,
    output resp_word_t                  resp_fifo_wdata,

    output logic                        clear_run,
    output logic                        update_nxt_desc_ptr,
    output logic [`PF_ADDR_WIDTH-1:0]   updated_ptr_desc,
    output logic                        reset_complete
);

    // Fixed tag expected by the dispatcher
    localparam logic [1:0] DISPATCH_TAG = 2'b10;

    ctrl_state_t                    state;
    ctrl_state_t                    state_nxt;
    desc_control_t                  ctrl_word;
    logic                           owned;
    logic                           use_sw_ptr;
    logic [`PF_ADDR_WIDTH-1:0]      ptr_desc;
    logic [`PF_ADDR_WIDTH-1:0]      fetch_addr;
    logic [`PF_POLL_WIDTH-1:0]      poll_cnt;

    assign ctrl_word = rsp.desc.control;
    assign owned     = ctrl_word.owned_by_hw;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (run & ~reset_prefetcher) begin
                    state_nxt = RD_REQ;
                end
            end
            RD_REQ:  state_nxt = RD_WAIT;
            // Fetch master owns the word count, just wait for done
            RD_WAIT: begin
                if (rsp.done) begin
                    state_nxt = RD_DONE;
                end
            end
            RD_DONE: begin
                if (reset_prefetcher | (~owned & ~desc_poll_en)) begin
                    state_nxt = CLR_RUN;
                end else if (~owned & desc_poll_en) begin
                    state_nxt = POLL_LOAD;
                end else if (owned & ~resp_fifo_full) begin
                    state_nxt = WR_REQ;
                end
            end
            WR_REQ:  state_nxt = WR_WAIT;
            WR_WAIT: begin
                if (descr_valid & descr_ready) begin
                    state_nxt = WR_DONE;
                end
            end
            WR_DONE:   state_nxt = RD_REQ;
            POLL_LOAD: state_nxt = POLL_WAIT;
            POLL_WAIT: begin
                if (poll_cnt == '0) begin
                    state_nxt = RD_REQ;
                end
            end
            CLR_RUN: state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // Poll interval down-counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            poll_cnt <= '0;
        end else if (state == POLL_LOAD) begin
            poll_cnt <= desc_poll_freq;
        end else if (poll_cnt != '0) begin
            poll_cnt <= poll_cnt - 1'b1;
        end
    end

    // First fetch after IDLE comes from the software pointer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            use_sw_ptr <= 1'b0;
        end else if ((state == IDLE) && (state_nxt == RD_REQ)) begin
            use_sw_ptr <= 1'b1;
        end else if (state == WR_DONE) begin
            use_sw_ptr <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ptr_desc            <= '0;
            update_nxt_desc_ptr <= 1'b0;
        end else begin
            update_nxt_desc_ptr <= (state == WR_DONE) & desc_poll_en;
            if (state == WR_DONE) begin
                ptr_desc <= rsp.desc.next_ptr;
            end
        end
    end

    assign fetch_addr       = use_sw_ptr ? nxt_desc_ptr : ptr_desc;
    assign updated_ptr_desc = ptr_desc;

    assign req.start = (state == RD_REQ);
    assign req.addr  = fetch_addr;

    // Stream valid holds until the handshake
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            descr_valid <= 1'b0;
        end else if (state == WR_REQ) begin
            descr_valid <= 1'b1;
        end else if (descr_valid & descr_ready) begin
            descr_valid <= 1'b0;
        end
    end

    assign descr_data.tag        = DISPATCH_TAG;
    assign descr_data.flags      = ctrl_word.flags;
    assign descr_data.length     = rsp.desc.length;
    assign descr_data.write_addr = rsp.desc.write_addr;
    assign descr_data.read_addr  = rsp.desc.read_addr;

    // fetch_addr still points at this descriptor during WR_DONE
    assign put_resp_fifo              = (state == WR_DONE);
    assign resp_fifo_wdata.control    = ctrl_word;
    assign resp_fifo_wdata.fetch_addr = fetch_addr;

    assign clear_run = (state == CLR_RUN) | ((state == IDLE) & run & reset_prefetcher);

    // Set only from a safe point, then follows the request level
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reset_complete <= 1'b0;
        end else if (reset_complete) begin
            reset_complete <= reset_prefetcher;
        end else begin
            reset_complete <= reset_prefetcher & ((state == IDLE) | (state == CLR_RUN));
        end
    end

endmodule

//--- hw/desc_fetch_master.sv
`timescale 1ns/1ps
`include "prefetch_defs.svh"

module desc_fetch_master
    import desc_format_pkg::*, prefetch_ctrl_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,

    input  fetch_req_t                  req,
    output fetch_rsp_t                  rsp,

    output logic [`PF_ADDR_WIDTH-1:0]   mem_address,
    output logic                        mem_read,
    input  logic [`PF_DATA_WIDTH-1:0]   mem_readdata,
    input  logic                        mem_waitrequest,
    input  logic                        mem_readdatavalid
);

    localparam int LAST_IDX = `PF_DESC_WORDS - 1;
    localparam logic [`PF_WORD_CNT_WIDTH-1:0] LAST_WORD = LAST_IDX[`PF_WORD_CNT_WIDTH-1:0];

    logic [`PF_WORD_CNT_WIDTH-1:0]              req_cnt;
    logic [`PF_WORD_CNT_WIDTH-1:0]              beat_cnt;
    logic                                       beats_pending;
    logic                                       done_q;
    logic                                       accept;
    logic                                       beat_in;
    logic                                       last_beat;
    logic [`PF_DESC_WORDS-1:0][`PF_DATA_WIDTH-1:0] words;

    assign accept    = mem_read & ~mem_waitrequest;
    assign beat_in   = beats_pending & mem_readdatavalid;
    assign last_beat = beat_in & (beat_cnt == LAST_WORD);

    // Request side: one single-word read per accepted command
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_read    <= 1'b0;
            mem_address <= '0;
            req_cnt     <= '0;
        end else if (req.start) begin
            mem_read    <= 1'b1;
            mem_address <= req.addr;
            req_cnt     <= '0;
        end else if (accept) begin
            mem_address <= mem_address + `PF_ADDR_STEP;
            req_cnt     <= req_cnt + 1'b1;
            // Eighth request accepted, stop asking
            if (req_cnt == LAST_WORD) begin
                mem_read <= 1'b0;
            end
        end
    end

    // Beat side, data returns in request order
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            beats_pending <= 1'b0;
            beat_cnt      <= '0;
            done_q        <= 1'b0;
        end else begin
            done_q <= last_beat;
            if (req.start) begin
                beats_pending <= 1'b1;
                beat_cnt      <= '0;
            end else if (beat_in) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    beats_pending <= 1'b0;
                end
            end
        end
    end

    // Beat k lands in word k
    always_ff @(posedge clk) begin
        if (beat_in) begin
            words[beat_cnt] <= mem_readdata;
        end
    end

    assign rsp.done = done_q;
    assign rsp.desc = mem_desc_t'(words);

endmodule

//--- hw/prefetch_ctrl_pkg.sv
`include "prefetch_defs.svh"

package prefetch_ctrl_pkg;

    import desc_format_pkg::*;

    typedef enum logic [3:0] {
        IDLE      = 4'd0,
        RD_REQ    = 4'd1,
        RD_WAIT   = 4'd2,
        RD_DONE   = 4'd3,
        WR_REQ    = 4'd4,
        WR_WAIT   = 4'd5,
        WR_DONE   = 4'd6,
        POLL_LOAD = 4'd7,
        POLL_WAIT = 4'd8,
        CLR_RUN   = 4'd9
    } ctrl_state_t;

    // Controller to fetch master
    typedef struct packed {
        logic                       start;
        logic [`PF_ADDR_WIDTH-1:0]  addr;
    } fetch_req_t;

    // Fetch master back to the controller
    typedef struct packed {
        logic       done;
        mem_desc_t  desc;
    } fetch_rsp_t;

endpackage

//--- hw/desc_format_pkg.sv
`include "prefetch_defs.svh"

package desc_format_pkg;

    // Control word, last word of the in-memory descriptor
    typedef struct packed {
        logic        go;
        logic        owned_by_hw;
        logic [29:0] flags;
    } desc_control_t;

    // Word 0 sits in the low bits, word 7 in the high bits
    typedef struct packed {
        desc_control_t                      control;
        logic [2:0][`PF_DATA_WIDTH-1:0]     reserved;
        logic [`PF_ADDR_WIDTH-1:0]          next_ptr;
        logic [`PF_DATA_WIDTH-1:0]          length;
        logic [`PF_ADDR_WIDTH-1:0]          write_addr;
        logic [`PF_ADDR_WIDTH-1:0]          read_addr;
    } mem_desc_t;

    // Word handed to the dispatcher stream
    typedef struct packed {
        logic [1:0]                 tag;
        logic [29:0]                flags;
        logic [`PF_DATA_WIDTH-1:0]  length;
        logic [`PF_ADDR_WIDTH-1:0]  write_addr;
        logic [`PF_ADDR_WIDTH-1:0]  read_addr;
    } dispatch_desc_t;

    // Response FIFO entry
    typedef struct packed {
        desc_control_t              control;
        // Address the descriptor was read from
        logic [`PF_ADDR_WIDTH-1:0]  fetch_addr;
    } resp_word_t;

endpackage

//--- hw/prefetch_defs.svh
`ifndef PREFETCH_DEFS_SVH
`define PREFETCH_DEFS_SVH

// Memory read port
`define PF_DATA_WIDTH 32
`define PF_ADDR_WIDTH 32

// One descriptor in memory is eight words
`define PF_DESC_WORDS 8

// Byte step between consecutive word reads
`define PF_ADDR_STEP 4

// Poll interval counter
`define PF_POLL_WIDTH 16

// Wide enough to index every word of a descriptor
`define PF_WORD_CNT_WIDTH 3

`endif
